// File: Bender.yml
package:
  name: carbon_mini

sources:
  - include_dirs:
      - hw
    files:
      - hw/carbon_mini_pkg.sv
      - hw/sys_init_seq.sv
      - hw/cpu_decode.sv
      - hw/cpu_execute.sv
      - hw/cpu_result.sv
      - hw/mmio_regs.sv
      - hw/carbon_mini_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tb/carbon_mini_tb.sv

// File: carbon_mini.f
+incdir+hw
hw/carbon_mini_pkg.sv
hw/sys_init_seq.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_result.sv
hw/mmio_regs.sv
hw/carbon_mini_top.sv
tb/carbon_mini_tb.sv

// File: hw/carbon_mini_defs.svh
/* Fixed widths, CSR and MMIO addresses and reset values for the carbon_mini system.
   Included by the package and by every module that needs a width or an address. */
`ifndef CARBON_MINI_DEFS_SVH
`define CARBON_MINI_DEFS_SVH

// Widths
`define CM_PROG_AW   6
`define CM_INSN_W    16
`define CM_DATA_W    8
`define CM_OPCODE_W  4
`define CM_CSR_AW    7
`define CM_MMIO_AW   3

// CSR map and reset values
`define CM_CSR_MODEFLAGS  7'd0
`define CM_MODE_RESET     1'b1

// MMIO store addresses
`define CM_MMIO_SIG0      3'd0
`define CM_MMIO_SIG1      3'd1
`define CM_MMIO_SIG2      3'd2
`define CM_MMIO_SIG3      3'd3
`define CM_MMIO_POWEROFF  3'd4

`endif

// File: hw/carbon_mini_pkg.sv
/* Shared enums and packed structs of the carbon_mini system.
   Compiled first and imported by the RTL and the testbench. */
`include "carbon_mini_defs.svh"

package carbon_mini_pkg;

  // Opcode field, bits 15 to 12 of an instruction
  typedef enum logic [`CM_OPCODE_W-1:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_ADD  = 4'h2,
    OP_XOR  = 4'h3,
    OP_MUL  = 4'h4,
    OP_STO  = 4'h5,
    OP_JMP  = 4'h6,
    OP_JNZ  = 4'h7,
    OP_HALT = 4'hf
  } opcode_e;

  typedef enum logic [1:0] {
    INIT_MODE,
    INIT_WAIT,
    INIT_DONE
  } init_state_e;

  typedef struct packed {
    logic                  valid;
    opcode_e               op;
    logic [`CM_DATA_W-1:0] operand;
  } decoded_t;

  // All enables are one-cycle strobes
  typedef struct packed {
    logic                   acc_we;
    logic [`CM_DATA_W-1:0]  acc_next;
    logic                   store_en;
    logic [`CM_MMIO_AW-1:0] store_addr;
    logic [`CM_DATA_W-1:0]  store_data;
    logic                   branch_en;
    logic [`CM_PROG_AW-1:0] branch_target;
    logic                   halt;
  } exec_t;

  typedef struct packed {
    logic                  valid;
    logic [`CM_CSR_AW-1:0] addr;
    logic [`CM_DATA_W-1:0] data;
  } csr_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`CM_MMIO_AW-1:0] addr;
    logic [`CM_DATA_W-1:0]  data;
  } mmio_req_t;

endpackage : carbon_mini_pkg

// File: hw/carbon_mini_top.sv
/* Top of the carbon_mini system: init sequencer, three-stage accumulator CPU and MMIO.
   Programs come in through the load port; signature and poweroff report the result. */
`timescale 1ns/1ps
`include "carbon_mini_defs.svh"

module carbon_mini_top import carbon_mini_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_en,
  input  logic [`CM_PROG_AW-1:0] load_addr,
  input  logic [`CM_INSN_W-1:0]  load_data,
  input  logic                   strict_boot,
  output logic [31:0]            signature,
  output logic                   poweroff,
  output logic                   running
);

  csr_req_t               csr;
  logic                   run_release;
  decoded_t               dec;
  exec_t                  ex;
  logic [`CM_DATA_W-1:0]  acc;
  logic                   mode_strict;
  logic                   branch_en;
  logic [`CM_PROG_AW-1:0] branch_target;
  mmio_req_t              mmio;

  // --------------------
  // Boot control

  sys_init_seq u_init (
    .clk         (clk),
    .rst_n       (rst_n),
    .strict_boot (strict_boot),
    .csr         (csr),
    .run_release (run_release)
  );

  // --------------------
  // CPU

  cpu_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .running       (running),
    .branch_en     (branch_en),
    .branch_target (branch_target),
    .dec           (dec)
  );

  cpu_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec         (dec),
    .acc         (acc),
    .mode_strict (mode_strict),
    .ex          (ex)
  );

  cpu_result u_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex            (ex),
    .csr           (csr),
    .run_release   (run_release),
    .acc           (acc),
    .mode_strict   (mode_strict),
    .branch_en     (branch_en),
    .branch_target (branch_target),
    .mmio          (mmio),
    .running       (running)
  );

  // --------------------
  // MMIO

  mmio_regs u_mmio (
    .clk       (clk),
    .rst_n     (rst_n),
    .mmio      (mmio),
    .signature (signature),
    .poweroff  (poweroff)
  );

endmodule : carbon_mini_top

// File: hw/cpu_decode.sv
/* Program RAM, program counter and instruction decode of the accumulator CPU.
   Fetches one instruction every three cycles while running is high. */
`timescale 1ns/1ps
`include "carbon_mini_defs.svh"

module cpu_decode import carbon_mini_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_en,
  input  logic [`CM_PROG_AW-1:0] load_addr,
  input  logic [`CM_INSN_W-1:0]  load_data,
  input  logic                   running,
  input  logic                   branch_en,
  input  logic [`CM_PROG_AW-1:0] branch_target,
  output decoded_t               dec
);

  typedef enum logic [1:0] {
    PH_FETCH,
    PH_EXEC,
    PH_RESULT
  } phase_e;

  logic [`CM_INSN_W-1:0]  prog_mem [2**`CM_PROG_AW];
  logic [`CM_PROG_AW-1:0] pc_q;
  logic [`CM_INSN_W-1:0]  insn;
  phase_e                 phase_q;

  // Unknown opcodes become NOP, the operand passes through unchanged
  function automatic decoded_t decode_insn(input logic [`CM_INSN_W-1:0] word);
    decoded_t d;
    d.valid   = 1'b1;
    d.operand = word[`CM_DATA_W-1:0];
    case (word[`CM_INSN_W-1 -: `CM_OPCODE_W])
      OP_LDI, OP_ADD, OP_XOR, OP_MUL, OP_STO, OP_JMP, OP_JNZ, OP_HALT: begin
        d.op = opcode_e'(word[`CM_INSN_W-1 -: `CM_OPCODE_W]);
      end
      default: begin
        d.op = OP_NOP;
      end
    endcase
    return d;
  endfunction

  // --------------------
  // Program RAM

  // Load port is live in reset as well
  always_ff @(posedge clk) begin
    if (load_en) begin
      prog_mem[load_addr] <= load_data;
    end
  end

  assign insn = prog_mem[pc_q];

  // --------------------
  // Phase sequencer and PC

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PH_FETCH;
      pc_q    <= '0;
      dec     <= '0;
    end else begin
      dec.valid <= 1'b0;
      // Branches arrive during the result phase, ahead of the next fetch
      if (branch_en) begin
        pc_q <= branch_target;
      end
      case (phase_q)
        PH_FETCH: begin
          if (running) begin
            dec     <= decode_insn(insn);
            pc_q    <= pc_q + 1'b1;
            phase_q <= PH_EXEC;
          end
        end
        PH_EXEC:   phase_q <= PH_RESULT;
        PH_RESULT: phase_q <= PH_FETCH;
        default:   phase_q <= PH_FETCH;
      endcase
    end
  end

endmodule : cpu_decode

// File: hw/cpu_execute.sv
/* ALU stage of the accumulator CPU.
   Turns each decoded instruction into one registered exec_t result. */
`timescale 1ns/1ps
`include "carbon_mini_defs.svh"

module cpu_execute import carbon_mini_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  decoded_t              dec,
  input  logic [`CM_DATA_W-1:0] acc,
  input  logic                  mode_strict,
  output exec_t                 ex
);

  exec_t                   ex_d;
  logic [2*`CM_DATA_W-1:0] mul_full;

  assign mul_full = acc * dec.operand;

  // --------------------
  // Next state of the accumulator, store and branch

  always_comb begin
    ex_d = '0;
    if (dec.valid) begin
      case (dec.op)
        OP_LDI: begin
          ex_d.acc_we   = 1'b1;
          ex_d.acc_next = dec.operand;
        end
        OP_ADD: begin
          ex_d.acc_we   = 1'b1;
          ex_d.acc_next = acc + dec.operand;
        end
        OP_XOR: begin
          ex_d.acc_we   = 1'b1;
          ex_d.acc_next = acc ^ dec.operand;
        end
        OP_MUL: begin
          // Strict mode turns the multiply into a no-op
          if (!mode_strict) begin
            ex_d.acc_we   = 1'b1;
            ex_d.acc_next = mul_full[`CM_DATA_W-1:0];
          end
        end
        OP_STO: begin
          ex_d.store_en   = 1'b1;
          ex_d.store_addr = dec.operand[`CM_MMIO_AW-1:0];
          ex_d.store_data = acc;
        end
        OP_JMP: begin
          ex_d.branch_en     = 1'b1;
          ex_d.branch_target = dec.operand[`CM_PROG_AW-1:0];
        end
        OP_JNZ: begin
          ex_d.branch_en     = (acc != '0);
          ex_d.branch_target = dec.operand[`CM_PROG_AW-1:0];
        end
        OP_HALT: begin
          ex_d.halt = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // One-cycle result, cleared between instructions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex <= '0;
    end else begin
      ex <= ex_d;
    end
  end

endmodule : cpu_execute

// File: hw/cpu_result.sv
/* Result stage of the accumulator CPU.
   Holds acc and the mode CSR, issues stores and branches and decides when the core runs. */
`timescale 1ns/1ps
`include "carbon_mini_defs.svh"

module cpu_result import carbon_mini_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  exec_t                  ex,
  input  csr_req_t               csr,
  input  logic                   run_release,
  output logic [`CM_DATA_W-1:0]  acc,
  output logic                   mode_strict,
  output logic                   branch_en,
  output logic [`CM_PROG_AW-1:0] branch_target,
  output mmio_req_t              mmio,
  output logic                   running
);

  logic stop_q;
  logic stop_set;

  // HALT or a nonzero poweroff store ends the run
  assign stop_set = ex.halt ||
                    (ex.store_en && (ex.store_addr == `CM_MMIO_POWEROFF) &&
                     (ex.store_data != '0));

  // Stores and branches leave in the result phase itself
  assign mmio.valid    = ex.store_en;
  assign mmio.addr     = ex.store_addr;
  assign mmio.data     = ex.store_data;
  assign branch_en     = ex.branch_en;
  assign branch_target = ex.branch_target;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc         <= '0;
      mode_strict <= `CM_MODE_RESET;
      stop_q      <= 1'b0;
      running     <= 1'b0;
    end else begin
      if (ex.acc_we) begin
        acc <= ex.acc_next;
      end
      if (csr.valid && (csr.addr == `CM_CSR_MODEFLAGS)) begin
        mode_strict <= csr.data[0];
      end
      if (stop_set) begin
        stop_q <= 1'b1;
      end
      running <= run_release && !stop_q && !stop_set;
    end
  end

endmodule : cpu_result

// File: hw/mmio_regs.sv
/* Memory-mapped signature bytes and sticky poweroff flag.
   Written by CPU stores; everything is ignored once poweroff is set. */
`timescale 1ns/1ps
`include "carbon_mini_defs.svh"

module mmio_regs import carbon_mini_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  mmio_req_t   mmio,
  output logic [31:0] signature,
  output logic        poweroff
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      signature <= '0;
      poweroff  <= 1'b0;
    end else if (mmio.valid && !poweroff) begin
      case (mmio.addr)
        `CM_MMIO_SIG0: signature[7:0]   <= mmio.data;
        `CM_MMIO_SIG1: signature[15:8]  <= mmio.data;
        `CM_MMIO_SIG2: signature[23:16] <= mmio.data;
        `CM_MMIO_SIG3: signature[31:24] <= mmio.data;
        `CM_MMIO_POWEROFF: begin
          // Zero writes leave the system running
          if (mmio.data != '0) begin
            poweroff <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule : mmio_regs

// File: hw/sys_init_seq.sv
/* Post-reset init sequencer. Clears the CPU strict mode unless strict_boot is set,
   then releases the core and keeps it released until the next reset. */
`timescale 1ns/1ps
`include "carbon_mini_defs.svh"

module sys_init_seq import carbon_mini_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     strict_boot,
  output csr_req_t csr,
  output logic     run_release
);

  init_state_e state_q;

  // --------------------
  // Sequence

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= INIT_MODE;
    end else begin
      case (state_q)
        INIT_MODE: state_q <= INIT_WAIT;
        INIT_WAIT: state_q <= INIT_DONE;
        INIT_DONE: state_q <= INIT_DONE;
        default:   state_q <= INIT_MODE;
      endcase
    end
  end

  // --------------------
  // CSR write and release

  // Mode write is taken on the first edge after reset
  always_comb begin
    csr = '0;
    if ((state_q == INIT_MODE) && !strict_boot) begin
      csr.valid = 1'b1;
      csr.addr  = `CM_CSR_MODEFLAGS;
      csr.data  = '0;
    end
  end

  // Core stays halted until the mode write has settled
  assign run_release = (state_q == INIT_DONE);

endmodule : sys_init_seq

// File: tb/carbon_mini_tb.sv
/* Testbench of the carbon_mini system. Loads small programs in reset, runs them and
   compares signature and poweroff against a reference model of the instruction set. */
`timescale 1ns/1ps
`include "carbon_mini_defs.svh"

module carbon_mini_tb import carbon_mini_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int DRIVE_DLY       = 1;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 6;
  localparam int MAX_STEPS       = 100;
  localparam int INIT_CYCLES     = 2**`CM_PROG_AW + RESET_CYCLES + 4;
  localparam int START_LIMIT     = 10;
  localparam int RUN_LIMIT       = 3 * MAX_STEPS + 20;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (INIT_CYCLES + 3 * MAX_STEPS + 20);

  logic                   clk;
  logic                   rst_n;
  logic                   load_en;
  logic [`CM_PROG_AW-1:0] load_addr;
  logic [`CM_INSN_W-1:0]  load_data;
  logic                   strict_boot;
  logic [31:0]            signature;
  logic                   poweroff;
  logic                   running;

  logic [`CM_INSN_W-1:0]  prog [2**`CM_PROG_AW];
  int                     prog_len = 0;
  int                     err_cnt = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;

  carbon_mini_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .strict_boot (strict_boot),
    .signature   (signature),
    .poweroff    (poweroff),
    .running     (running)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // Rules checked every cycle

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!running && !poweroff))
    else begin
      err_cnt++;
      $display("%0t: running or poweroff high while in reset", $time);
    end

  // Init sequence keeps the core halted for the first cycles
  a_init_hold: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(rst_n) |-> (!running && !poweroff) ##1 !running ##1 !running)
    else begin
      err_cnt++;
      $display("%0t: running rose before the init sequence finished", $time);
    end

  a_sig_frozen: assert property (@(posedge clk) disable iff (!rst_n)
      poweroff |=> $stable(signature))
    else begin
      err_cnt++;
      $display("%0t: signature changed after poweroff", $time);
    end

  a_stop_on_off: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(poweroff) |-> !running)
    else begin
      err_cnt++;
      $display("%0t: core still running after poweroff", $time);
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Checks failed");
    $finish;
  end

  // --------------------
  // Helpers

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      err_cnt++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic clear_program();
    prog_len = 0;
  endtask

  task automatic emit(input opcode_e op, input logic [7:0] arg);
    prog[prog_len] = {op, 4'h0, arg};
    prog_len++;
  endtask

  // Instruction set semantics applied word by word
  task automatic model_run(input logic strict, output logic [31:0] sig, output logic poff);
    logic [`CM_PROG_AW-1:0] pc;
    logic [7:0]             acc;
    logic [7:0]             arg;
    logic [3:0]             op;
    logic                   stop;
    int                     steps;
    pc = '0;
    acc = '0;
    sig = '0;
    poff = 1'b0;
    stop = 1'b0;
    steps = 0;
    while (!stop && steps < MAX_STEPS) begin
      op = prog[pc][15:12];
      arg = prog[pc][7:0];
      pc = pc + 1'b1;
      steps++;
      case (op)
        OP_LDI: acc = arg;
        OP_ADD: acc = acc + arg;
        OP_XOR: acc = acc ^ arg;
        OP_MUL: if (!strict) acc = acc * arg;
        OP_STO: begin
          if (!poff && arg[2:0] < 3'd4) begin
            sig[arg[1:0]*8 +: 8] = acc;
          end
          if (arg[2:0] == `CM_MMIO_POWEROFF && acc != '0) begin
            poff = 1'b1;
            stop = 1'b1;
          end
        end
        OP_JMP: pc = arg[`CM_PROG_AW-1:0];
        OP_JNZ: if (acc != '0) pc = arg[`CM_PROG_AW-1:0];
        OP_HALT: stop = 1'b1;
        default: ;
      endcase
    end
    if (!stop) begin
      err_cnt++;
      $display("Reference model found no stop within %0d steps", MAX_STEPS);
    end
  endtask

  task automatic reset_and_load(input logic strict);
    @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b0;
    strict_boot = strict;
    for (int i = 0; i < prog_len; i++) begin
      load_en = 1'b1;
      load_addr = `CM_PROG_AW'(i);
      load_data = prog[i];
      @(posedge clk);
      #DRIVE_DLY;
    end
    load_en = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_start(output int cycles);
    cycles = 0;
    rst_n = 1'b1;
    while (!running && cycles < START_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    if (!running) begin
      err_cnt++;
      $display("%0t: core never started after reset release", $time);
    end
  endtask

  task automatic wait_stop();
    int cycles;
    cycles = 0;
    while (running && cycles < RUN_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    if (running) begin
      err_cnt++;
      $display("%0t: core still running after %0d cycles", $time, RUN_LIMIT);
    end
  endtask

  task automatic run_program(input logic strict);
    logic [31:0] exp_sig;
    logic        exp_poff;
    int          cycles;
    model_run(strict, exp_sig, exp_poff);
    reset_and_load(strict);
    wait_start(cycles);
    check_value("start latency", 32'd3, 32'(cycles));
    wait_stop();
    check_value("signature", exp_sig, signature);
    check_value("poweroff", 32'(exp_poff), 32'(poweroff));
    check_value("running", 32'd0, 32'(running));
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt != errs_before) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  // --------------------
  // Tests

  initial begin
    logic [7:0]  r [6];
    logic [7:0]  n_loop;
    logic [31:0] sig_hold;
    int          errs_before;
    int          cycles;
    int          seed_dummy;
    rst_n = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    strict_boot = 1'b0;
    seed_dummy = $urandom(32'hfb493cfa);
    for (int k = 0; k < 6; k++) begin
      r[k] = 8'($urandom());
    end

    // Reset state and start latency
    errs_before = err_cnt;
    clear_program();
    emit(OP_HALT, 8'h00);
    reset_and_load(1'b0);
    check_value("signature", 32'd0, signature);
    check_value("poweroff", 32'd0, 32'(poweroff));
    check_value("running", 32'd0, 32'(running));
    wait_start(cycles);
    check_value("start latency", 32'd3, 32'(cycles));
    wait_stop();
    check_value("signature", 32'd0, signature);
    report_test("reset state", errs_before);

    errs_before = err_cnt;
    clear_program();
    for (int k = 0; k < 4; k++) begin
      emit(OP_LDI, r[k]);
      emit(OP_STO, 8'(k));
    end
    emit(OP_LDI, r[4] | 8'h01);
    emit(OP_STO, 8'(`CM_MMIO_POWEROFF));
    emit(OP_HALT, 8'h00);
    run_program(1'b0);
    report_test("signature", errs_before);

    // The same program runs twice and MUL only counts with strict mode cleared
    clear_program();
    emit(OP_LDI, r[0]);
    emit(OP_ADD, r[1]);
    emit(OP_STO, 8'd0);
    emit(OP_XOR, r[2]);
    emit(OP_STO, 8'd1);
    emit(OP_MUL, r[3] | 8'h02);
    emit(OP_STO, 8'd2);
    emit(OP_ADD, r[4]);
    emit(OP_MUL, r[5] | 8'h01);
    emit(OP_STO, 8'd3);
    emit(OP_HALT, 8'h00);
    errs_before = err_cnt;
    run_program(1'b0);
    report_test("arithmetic", errs_before);
    errs_before = err_cnt;
    run_program(1'b1);
    report_test("strict boot", errs_before);

    // Countdown loop, then a jump over the store at 7
    errs_before = err_cnt;
    n_loop = 8'($urandom_range(5, 2));
    clear_program();
    emit(OP_LDI, n_loop);
    emit(OP_STO, 8'd1);
    emit(OP_ADD, 8'hff);
    emit(OP_STO, 8'd0);
    emit(OP_JNZ, 8'd2);
    emit(OP_JMP, 8'd8);
    emit(OP_LDI, 8'hee);
    emit(OP_STO, 8'd2);
    emit(OP_LDI, r[0]);
    emit(OP_STO, 8'd3);
    emit(OP_HALT, 8'h00);
    run_program(1'b0);
    report_test("control flow", errs_before);

    errs_before = err_cnt;
    clear_program();
    emit(OP_LDI, 8'h00);
    emit(OP_STO, 8'(`CM_MMIO_POWEROFF));
    emit(OP_LDI, r[1]);
    emit(OP_STO, 8'd0);
    emit(OP_LDI, 8'h01);
    emit(OP_STO, 8'(`CM_MMIO_POWEROFF));
    emit(OP_LDI, r[2]);
    emit(OP_STO, 8'd1);
    emit(OP_HALT, 8'h00);
    run_program(1'b0);
    // Only lane 0 was written before the poweroff store
    sig_hold = {24'h000000, r[1]};
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    check_value("signature", sig_hold, signature);
    report_test("after poweroff", errs_before);

    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : carbon_mini_tb
